// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rvPkg.sv
  - hdl/rvFetch.sv
  - hdl/rvDecode.sv
  - hdl/rvRegFile.sv
  - hdl/rvExecute.sv
  - hdl/rvWriteback.sv
  - hdl/rvCore.sv
  - target: test
    files:
      - test/rvCore_sva.sv
      - test/rvCoreTb.sv

// ==== hdl/rvCore.sv ====
// --------------------------------------------------
// Pipelined RV32I core with external memory ports
// --------------------------------------------------

`timescale 1ns/1ns

module rvCore #(
	parameter int ImemAddrWidth = 7
) (
	input logic clk,
	input logic async_reset,
	output logic [ImemAddrWidth-1:0] pc,
	input logic [rvPkg::XLen-1:0] instr,
	output logic [rvPkg::XLen-1:0] dataAddr,
	output logic [rvPkg::XLen-1:0] storeData,
	output logic dataWrite,
	output logic dataRead,
	input logic [rvPkg::XLen-1:0] loadData,
	output rvPkg::wbT wb
);

	logic stall;
	logic [rvPkg::XLen-1:0] ifId;
	logic [rvPkg::RegAddrWidth-1:0] rs1Addr;
	logic [rvPkg::RegAddrWidth-1:0] rs2Addr;
	logic [rvPkg::XLen-1:0] rs1Data;
	logic [rvPkg::XLen-1:0] rs2Data;
	rvPkg::idExT idEx;
	rvPkg::exMemT exMem;

	rvFetch #(
		.ImemAddrWidth(ImemAddrWidth)
	) fetch (
		.clk(clk),
		.async_reset(async_reset),
		.stall(stall),
		.instr(instr),
		.pc(pc),
		.ifId(ifId)
	);

	rvDecode decode (
		.clk(clk),
		.async_reset(async_reset),
		.ifId(ifId),
		.rs1Addr(rs1Addr),
		.rs2Addr(rs2Addr),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.idEx(idEx),
		.stall(stall)
	);

	rvRegFile regFile (
		.clk(clk),
		.async_reset(async_reset),
		.rs1Addr(rs1Addr),
		.rs2Addr(rs2Addr),
		.wb(wb),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	rvExecute execute (
		.clk(clk),
		.async_reset(async_reset),
		.idEx(idEx),
		.wb(wb),                               // Second forwarding source
		.exMem(exMem),
		.dataAddr(dataAddr),
		.storeData(storeData),
		.dataWrite(dataWrite),
		.dataRead(dataRead)
	);

	rvWriteback writeback (
		.clk(clk),
		.async_reset(async_reset),
		.exMem(exMem),
		.loadData(loadData),
		.wb(wb)
	);

endmodule

// ==== hdl/rvDecode.sv ====
// --------------------------------------------------
// Instruction decode, load-use stall and ID/EX register
// --------------------------------------------------

`timescale 1ns/1ns

module rvDecode (
	input logic clk,
	input logic async_reset,
	input logic [rvPkg::XLen-1:0] ifId,
	output logic [rvPkg::RegAddrWidth-1:0] rs1Addr,
	output logic [rvPkg::RegAddrWidth-1:0] rs2Addr,
	input logic [rvPkg::XLen-1:0] rs1Data,
	input logic [rvPkg::XLen-1:0] rs2Data,
	output rvPkg::idExT idEx,
	output logic stall
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic funct7b5;
	logic [rvPkg::RegAddrWidth-1:0] rd;
	logic [rvPkg::XLen-1:0] imm;
	logic useRs1;
	logic useRs2;
	rvPkg::ctrlT ctrl;
	rvPkg::idExT idExNext;

	// Shared by R-type and I-type, SUB only exists for R-type
	function automatic rvPkg::aluOpT aluFromFunct3(
		input logic [2:0] f3,
		input logic alt,
		input logic isReg
	);
		rvPkg::aluOpT op;
		case (f3)
			3'b000: op = (alt && isReg) ? rvPkg::AluSub : rvPkg::AluAdd;
			3'b001: op = rvPkg::AluSll;
			3'b010: op = rvPkg::AluSlt;
			3'b011: op = rvPkg::AluSltu;
			3'b100: op = rvPkg::AluXor;
			3'b101: op = alt ? rvPkg::AluSra : rvPkg::AluSrl;
			3'b110: op = rvPkg::AluOr;
			default: op = rvPkg::AluAnd;
		endcase
		return op;
	endfunction

	assign opcode = ifId[6:0];
	assign rd = ifId[11:7];
	assign funct3 = ifId[14:12];
	assign rs1Addr = ifId[19:15];
	assign rs2Addr = ifId[24:20];
	assign funct7b5 = ifId[30];

	always_comb
	begin
		ctrl = '0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		case (opcode)
			rvPkg::OpReg:
			begin
				ctrl.aluOp = aluFromFunct3(funct3, funct7b5, 1'b1);
				ctrl.regWrite = 1'b1;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
			rvPkg::OpImm:
			begin
				ctrl.aluOp = aluFromFunct3(funct3, funct7b5, 1'b0);
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
				useRs1 = 1'b1;
			end
			rvPkg::OpLoad:
			begin
				ctrl.aluOp = rvPkg::AluAdd;
				ctrl.useImm = 1'b1;
				ctrl.loadEn = 1'b1;
				ctrl.regWrite = 1'b1;
				useRs1 = 1'b1;
				case (funct3)
					3'b000: ctrl.loadKind = rvPkg::LoadByte;
					3'b001: ctrl.loadKind = rvPkg::LoadHalf;
					3'b100: ctrl.loadKind = rvPkg::LoadByteU;
					3'b101: ctrl.loadKind = rvPkg::LoadHalfU;
					default: ctrl.loadKind = rvPkg::LoadWord;
				endcase
			end
			rvPkg::OpStore:
			begin
				ctrl.aluOp = rvPkg::AluAdd;
				ctrl.useImm = 1'b1;
				ctrl.storeEn = 1'b1;
				useRs1 = 1'b1;
				useRs2 = 1'b1;                 // Store data
			end
			default:
			begin
				ctrl = '0;                     // Unknown opcode is a bubble
			end
		endcase
		if (rd == '0)
			ctrl.regWrite = 1'b0;
	end

	// S-type splits the immediate around rd
	assign imm = (opcode == rvPkg::OpStore)
		? {{(rvPkg::XLen-12){ifId[31]}}, ifId[31:25], ifId[11:7]}
		: {{(rvPkg::XLen-12){ifId[31]}}, ifId[31:20]};

	// Load in execute whose result is needed right now
	assign stall = idEx.ctrl.loadEn && idEx.ctrl.regWrite
		&& ((useRs1 && idEx.rd == rs1Addr) || (useRs2 && idEx.rd == rs2Addr));

	always_comb
	begin
		idExNext.ctrl = stall ? '0 : ctrl;
		idExNext.rs1Val = rs1Data;
		idExNext.rs2Val = rs2Data;
		idExNext.imm = imm;
		idExNext.rd = rd;
		idExNext.rs1 = rs1Addr;
		idExNext.rs2 = rs2Addr;
	end

	always_ff @(posedge clk or negedge async_reset)
	begin
		if (!async_reset)
			idEx <= '0;
		else
			idEx <= idExNext;
	end

endmodule

// ==== hdl/rvExecute.sv ====
// --------------------------------------------------
// Operand forwarding, ALU and EX/MEM register
// --------------------------------------------------

`timescale 1ns/1ns

module rvExecute (
	input logic clk,
	input logic async_reset,
	input rvPkg::idExT idEx,
	input rvPkg::wbT wb,
	output rvPkg::exMemT exMem,
	output logic [rvPkg::XLen-1:0] dataAddr,
	output logic [rvPkg::XLen-1:0] storeData,
	output logic dataWrite,
	output logic dataRead
);

	logic [rvPkg::XLen-1:0] src1;
	logic [rvPkg::XLen-1:0] src2;
	logic [rvPkg::XLen-1:0] opB;
	logic [rvPkg::XLen-1:0] aluResult;
	logic [4:0] shamt;
	rvPkg::exMemT exMemNext;

	// Youngest result wins, then writeback, then the register file
	function automatic logic [rvPkg::XLen-1:0] forwardSrc(
		input logic [rvPkg::RegAddrWidth-1:0] addr,
		input logic [rvPkg::XLen-1:0] regVal,
		input rvPkg::exMemT fwdMem,
		input rvPkg::wbT fwdWb
	);
		if (fwdMem.regWrite && fwdMem.rd == addr)
			return fwdMem.aluResult;
		else if (fwdWb.valid && fwdWb.rd == addr)
			return fwdWb.data;
		else
			return regVal;
	endfunction

	always_comb
	begin
		src1 = forwardSrc(idEx.rs1, idEx.rs1Val, exMem, wb);
		src2 = forwardSrc(idEx.rs2, idEx.rs2Val, exMem, wb);
	end

	assign opB = idEx.ctrl.useImm ? idEx.imm : src2;
	assign shamt = opB[4:0];

	always_comb
	begin
		case (idEx.ctrl.aluOp)
			rvPkg::AluAdd: aluResult = src1 + opB;
			rvPkg::AluSub: aluResult = src1 - opB;
			rvPkg::AluAnd: aluResult = src1 & opB;
			rvPkg::AluOr: aluResult = src1 | opB;
			rvPkg::AluXor: aluResult = src1 ^ opB;
			rvPkg::AluSll: aluResult = src1 << shamt;
			rvPkg::AluSrl: aluResult = src1 >> shamt;
			rvPkg::AluSra: aluResult = $signed(src1) >>> shamt;
			rvPkg::AluSlt:
				aluResult = {{(rvPkg::XLen-1){1'b0}}, $signed(src1) < $signed(opB)};
			rvPkg::AluSltu:
				aluResult = {{(rvPkg::XLen-1){1'b0}}, src1 < opB};
			default: aluResult = src1 + opB;
		endcase
	end

	always_comb
	begin
		exMemNext.loadEn = idEx.ctrl.loadEn;
		exMemNext.storeEn = idEx.ctrl.storeEn;
		exMemNext.regWrite = idEx.ctrl.regWrite;
		exMemNext.loadKind = idEx.ctrl.loadKind;
		exMemNext.rd = idEx.rd;
		exMemNext.aluResult = aluResult;
		exMemNext.storeData = src2;            // Forwarded rs2
	end

	always_ff @(posedge clk or negedge async_reset)
	begin
		if (!async_reset)
			exMem <= '0;
		else
			exMem <= exMemNext;
	end

	// Data memory is combinational and sits outside the core
	assign dataAddr = exMem.aluResult;
	assign storeData = exMem.storeData;
	assign dataWrite = exMem.storeEn;
	assign dataRead = exMem.loadEn;

endmodule

// ==== hdl/rvFetch.sv ====
// --------------------------------------------------
// Program counter and IF/ID instruction register
// --------------------------------------------------

`timescale 1ns/1ns

module rvFetch #(
	parameter int ImemAddrWidth = 7
) (
	input logic clk,
	input logic async_reset,
	input logic stall,
	input logic [rvPkg::XLen-1:0] instr,
	output logic [ImemAddrWidth-1:0] pc,
	output logic [rvPkg::XLen-1:0] ifId
);

	// No branches, so the pc only counts up or holds
	always_ff @(posedge clk or negedge async_reset)
	begin
		if (!async_reset)
		begin
			pc <= '0;
			ifId <= '0;                        // Zero word decodes as a bubble
		end
		else if (!stall)
		begin
			pc <= pc + 1'b1;                   // Wraps at the end of the space
			ifId <= instr;
		end
	end

endmodule

// ==== hdl/rvPkg.sv ====
// --------------------------------------------------
// RV32I core shared encodings and pipeline records
// --------------------------------------------------
package rvPkg;

	localparam int XLen = 32;
	localparam int RegAddrWidth = 5;

	// Major opcodes handled by the core
	typedef enum logic [6:0] {
		OpLoad = 7'b0000011,
		OpImm = 7'b0010011,
		OpStore = 7'b0100011,
		OpReg = 7'b0110011
	} opcodeT;

	typedef enum logic [3:0] {
		AluAdd = 4'd0,
		AluSub = 4'd1,
		AluAnd = 4'd2,
		AluOr = 4'd3,
		AluXor = 4'd4,
		AluSll = 4'd5,
		AluSrl = 4'd6,
		AluSra = 4'd7,
		AluSlt = 4'd8,
		AluSltu = 4'd9
	} aluOpT;

	typedef enum logic [2:0] {
		LoadWord = 3'd0,
		LoadHalf = 3'd1,
		LoadByte = 3'd2,
		LoadHalfU = 3'd3,
		LoadByteU = 3'd4
	} loadKindT;

	typedef struct packed {
		aluOpT aluOp;
		logic useImm;                          // Operand B from immediate
		logic loadEn;
		logic storeEn;
		logic regWrite;                        // Already low for rd x0
		loadKindT loadKind;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		logic [XLen-1:0] rs1Val;
		logic [XLen-1:0] rs2Val;
		logic [XLen-1:0] imm;
		logic [RegAddrWidth-1:0] rd;
		logic [RegAddrWidth-1:0] rs1;
		logic [RegAddrWidth-1:0] rs2;
	} idExT;

	typedef struct packed {
		logic loadEn;
		logic storeEn;
		logic regWrite;
		loadKindT loadKind;
		logic [RegAddrWidth-1:0] rd;
		logic [XLen-1:0] aluResult;            // Also the data address
		logic [XLen-1:0] storeData;
	} exMemT;

	typedef struct packed {
		logic loadEn;
		logic regWrite;
		loadKindT loadKind;
		logic [RegAddrWidth-1:0] rd;
		logic [XLen-1:0] aluResult;
		logic [XLen-1:0] loadWord;
	} memWbT;

	typedef struct packed {
		logic valid;
		logic [RegAddrWidth-1:0] rd;
		logic [XLen-1:0] data;
	} wbT;

endpackage

// ==== hdl/rvRegFile.sv ====
// --------------------------------------------------
// 32x32 register file with write-through bypass
// --------------------------------------------------

`timescale 1ns/1ns

module rvRegFile (
	input logic clk,
	input logic async_reset,
	input logic [rvPkg::RegAddrWidth-1:0] rs1Addr,
	input logic [rvPkg::RegAddrWidth-1:0] rs2Addr,
	input rvPkg::wbT wb,
	output logic [rvPkg::XLen-1:0] rs1Data,
	output logic [rvPkg::XLen-1:0] rs2Data
);

	logic [rvPkg::XLen-1:0] regs [1:31];      // x0 has no storage

	function automatic logic [rvPkg::XLen-1:0] readPort(
		input logic [rvPkg::RegAddrWidth-1:0] addr
	);
		if (addr == '0)
			return '0;
		else if (wb.valid && wb.rd == addr)
			return wb.data;                    // Same-cycle write
		else
			return regs[addr];
	endfunction

	always_comb
	begin
		rs1Data = readPort(rs1Addr);
		rs2Data = readPort(rs2Addr);
	end

	always_ff @(posedge clk or negedge async_reset)
	begin
		if (!async_reset)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb.valid && wb.rd != '0)
			regs[wb.rd] <= wb.data;
	end

endmodule

// ==== hdl/rvWriteback.sv ====
// --------------------------------------------------
// MEM/WB register and load extension into wb record
// --------------------------------------------------

`timescale 1ns/1ns

module rvWriteback (
	input logic clk,
	input logic async_reset,
	input rvPkg::exMemT exMem,
	input logic [rvPkg::XLen-1:0] loadData,
	output rvPkg::wbT wb
);

	rvPkg::memWbT memWb;
	logic [rvPkg::XLen-1:0] loadValue;

	always_ff @(posedge clk or negedge async_reset)
	begin
		if (!async_reset)
			memWb <= '0;
		else
		begin
			memWb.loadEn <= exMem.loadEn;
			memWb.regWrite <= exMem.regWrite;
			memWb.loadKind <= exMem.loadKind;
			memWb.rd <= exMem.rd;
			memWb.aluResult <= exMem.aluResult;
			memWb.loadWord <= loadData;        // Word at dataAddr this cycle
		end
	end

	// Subword loads take the low half or byte of the word
	always_comb
	begin
		case (memWb.loadKind)
			rvPkg::LoadHalf:
				loadValue = {{(rvPkg::XLen-16){memWb.loadWord[15]}}, memWb.loadWord[15:0]};
			rvPkg::LoadByte:
				loadValue = {{(rvPkg::XLen-8){memWb.loadWord[7]}}, memWb.loadWord[7:0]};
			rvPkg::LoadHalfU:
				loadValue = {{(rvPkg::XLen-16){1'b0}}, memWb.loadWord[15:0]};
			rvPkg::LoadByteU:
				loadValue = {{(rvPkg::XLen-8){1'b0}}, memWb.loadWord[7:0]};
			default:
				loadValue = memWb.loadWord;
		endcase
	end

	assign wb.valid = memWb.regWrite;
	assign wb.rd = memWb.rd;
	assign wb.data = memWb.loadEn ? loadValue : memWb.aluResult;

endmodule

// ==== tb.f ====
hdl/rvPkg.sv
hdl/rvFetch.sv
hdl/rvDecode.sv
hdl/rvRegFile.sv
hdl/rvExecute.sv
hdl/rvWriteback.sv
hdl/rvCore.sv
test/rvCore_sva.sv
test/rvCoreTb.sv

// ==== test/rvCoreTb.sv ====
// --------------------------------------------------
// Testbench for rvCore with random program and ISA model
// --------------------------------------------------

`timescale 1ns/1ns

module rvCoreTb;

	localparam int ImemAddrWidth = 7;
	localparam int ProgLen = 100;
	localparam int Timeout = 2000;
	localparam int KindAlu = 1;
	localparam int KindLoad = 2;
	localparam int KindLoadUse = 3;
	localparam int KindStore = 4;
	localparam int KindCount = 5;

	logic clk;
	logic async_reset;
	logic [ImemAddrWidth-1:0] pc;
	logic [rvPkg::XLen-1:0] instr;
	logic [rvPkg::XLen-1:0] dataAddr;
	logic [rvPkg::XLen-1:0] storeData;
	logic dataWrite;
	logic dataRead;
	logic [rvPkg::XLen-1:0] loadData;
	rvPkg::wbT wb;

	logic [31:0] imem [0:(1<<ImemAddrWidth)-1];
	logic [31:0] dmem [0:63];
	logic [31:0] modelMem [0:63];
	logic [31:0] modelReg [0:31];
	logic [15:0] lfsr;
	logic [36:0] expWb [$];                    // {rd, data}
	int expKind [$];
	logic [63:0] expSt [$];                    // {addr, data}
	logic [31:0] expLd [$];                    // Load addresses
	logic [36:0] wbExp;
	logic [63:0] stExp;
	logic [31:0] ldExp;
	int wbKind;
	logic storePending;
	logic [31:0] storeAddr;
	logic [31:0] storeVal;
	int checks [0:5];
	int errs [0:5];
	string testNames [0:5];
	int cycles;
	int totalChecks;
	int totalErrs;

	rvCore #(
		.ImemAddrWidth(ImemAddrWidth)
	) DUT (
		.clk(clk),
		.async_reset(async_reset),
		.pc(pc),
		.instr(instr),
		.dataAddr(dataAddr),
		.storeData(storeData),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.loadData(loadData),
		.wb(wb)
	);

	always #5 clk = ~clk;

	assign instr = imem[pc];
	assign loadData = dmem[dataAddr[7:2]];

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[15]};
			lfsr = lfsrNext(lfsr);
		end
		return v;
	endfunction

	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic subtract,
		input logic arith, input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return subtract ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'd0, $signed(a) < $signed(b)};
			3'b011: return {31'd0, a < b};
			3'b100: return a ^ b;
			3'b101:
			begin
				if (arith)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] extendLoad(input logic [2:0] f3, input logic [31:0] w);
		case (f3)
			3'b000: return {{24{w[7]}}, w[7:0]};
			3'b001: return {{16{w[15]}}, w[15:0]};
			3'b100: return {24'd0, w[7:0]};
			3'b101: return {16'd0, w[15:0]};
			default: return w;
		endcase
	endfunction

	// Generates the program and runs it on the sequential model
	task automatic buildProgram();
		logic [31:0] w;
		logic [31:0] res;
		logic [2:0] sel;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] prevLoadRd;
		logic [11:0] imm;
		logic alt;
		logic useRs2;
		logic writes;
		int kind;
		int op;
		prevLoadRd = '0;
		for (int i = 0; i < (1 << ImemAddrWidth); i++)
			imem[i] = 32'h0000_0013;               // addi x0, x0, 0
		for (int i = 0; i < 64; i++)
		begin
			dmem[i] = (i + 1) * 32'h9E37_79B9;
			modelMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++)
			modelReg[i] = '0;
		for (int i = 0; i < ProgLen; i++)
		begin
			sel = 3'(randBits(3));
			rd = 5'(randBits(3));
			rs1 = 5'(randBits(3));
			rs2 = 5'(randBits(3));
			kind = KindAlu;
			useRs2 = 1'b0;
			writes = 1'b1;
			if (sel <= 3'd2)
			begin
				f3 = 3'(randBits(3));
				alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'(randBits(1)) : 1'b0;
				w = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
				res = refAlu(f3, alt, alt, modelReg[rs1], modelReg[rs2]);
				useRs2 = 1'b1;
			end
			else if (sel <= 3'd4)
			begin
				f3 = 3'(randBits(3));
				imm = 12'(randBits(12));
				alt = 1'b0;
				if (f3 == 3'd1)
					imm[11:5] = '0;
				if (f3 == 3'd5)
				begin
					alt = 1'(randBits(1));
					imm[11:5] = {1'b0, alt, 5'd0};   // SRAI or SRLI
				end
				w = {imm, rs1, f3, rd, 7'b0010011};
				res = refAlu(f3, 1'b0, alt, modelReg[rs1], {{20{imm[11]}}, imm});
			end
			else if (sel <= 3'd6)
			begin
				op = int'(randBits(3)) % 5;
				f3 = (op < 3) ? 3'(op) : 3'(op + 1);
				rs1 = '0;
				imm = 12'(randBits(6) << 2);
				w = {imm, 5'd0, f3, rd, 7'b0000011};
				res = extendLoad(f3, modelMem[imm[7:2]]);
				expLd.push_back({20'd0, imm});
				kind = KindLoad;
			end
			else
			begin
				rs1 = '0;
				imm = 12'(randBits(6) << 2);
				w = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
				modelMem[imm[7:2]] = modelReg[rs2];
				expSt.push_back({20'd0, imm, modelReg[rs2]});
				writes = 1'b0;
			end
			if (prevLoadRd != '0 && (rs1 == prevLoadRd || (useRs2 && rs2 == prevLoadRd)))
				kind = (kind == KindAlu) ? KindLoadUse : kind;
			if (writes && rd != '0)
			begin
				modelReg[rd] = res;
				expWb.push_back({rd, res});
				expKind.push_back(kind);
			end
			prevLoadRd = (kind == KindLoad) ? rd : 5'd0;
			imem[i] = w;
		end
	endtask

	task automatic checkResetState();
		checks[0]++;
		assert (pc == '0 && !wb.valid && !dataWrite && !dataRead)
		else
		begin
			$display("ERR reset pc=%h wb.valid=%h dataWrite=%h dataRead=%h",
				pc, wb.valid, dataWrite, dataRead);
			errs[0]++;
		end
	endtask

	// Writeback, load and store monitor
	always @(negedge clk)
	begin
		if (async_reset && wb.valid)
		begin
			checks[KindCount]++;
			assert (wb.rd != '0)
			else
			begin
				$display("Writeback to x0 seen");
				errs[KindCount]++;
			end
			if (expWb.size() == 0)
			begin
				$display("Writeback seen after the last expected one");
				errs[KindCount]++;
			end
			else
			begin
				wbExp = expWb.pop_front();
				wbKind = expKind.pop_front();
				checks[wbKind]++;
				assert (wb.rd == wbExp[36:32])
				else
				begin
					$display("ERR wb.rd got %h expected %h", wb.rd, wbExp[36:32]);
					errs[wbKind]++;
				end
				assert (wb.data == wbExp[31:0])
				else
				begin
					$display("ERR wb.data got %h expected %h", wb.data, wbExp[31:0]);
					errs[wbKind]++;
				end
			end
		end
		if (async_reset && dataRead)
		begin
			if (expLd.size() == 0)
			begin
				$display("Load strobe seen after the last expected load");
				errs[KindLoad]++;
			end
			else
			begin
				ldExp = expLd.pop_front();
				checks[KindLoad]++;
				assert (dataAddr == ldExp)
				else
				begin
					$display("ERR dataAddr got %h expected %h", dataAddr, ldExp);
					errs[KindLoad]++;
				end
			end
		end
		if (async_reset && dataWrite)
		begin
			storePending = 1'b1;
			storeAddr = dataAddr;
			storeVal = storeData;
			if (expSt.size() == 0)
			begin
				$display("Store seen after the last expected one");
				errs[KindCount]++;
			end
			else
			begin
				stExp = expSt.pop_front();
				checks[KindStore]++;
				assert (dataAddr == stExp[63:32] && storeData == stExp[31:0])
				else
				begin
					$display("ERR dataAddr=%h storeData=%h expected %h %h",
						dataAddr, storeData, stExp[63:32], stExp[31:0]);
					errs[KindStore]++;
				end
			end
		end
	end

	// Data memory write lands just after the edge
	always @(posedge clk)
	begin
		#1;
		if (storePending)
		begin
			dmem[storeAddr[7:2]] = storeVal;
			storePending = 1'b0;
		end
	end

	initial
	begin
		clk = 1'b0;
		async_reset = 1'b0;
		storePending = 1'b0;
		lfsr = 16'd22946;
		testNames = '{"reset", "alu", "load", "load-use", "store", "count/x0"};
		for (int t = 0; t < 6; t++)
		begin
			checks[t] = 0;
			errs[t] = 0;
		end
		buildProgram();
		@(posedge clk);
		#1 checkResetState();
		@(posedge clk);
		#1 async_reset = 1'b1;
		@(negedge clk);
		checkResetState();
		$display("Test %s: %0d checks, %0d errors", testNames[0], checks[0], errs[0]);

		cycles = 0;
		while ((expWb.size() != 0 || expSt.size() != 0 || expLd.size() != 0)
			&& cycles < Timeout)
		begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= Timeout)
		begin
			$display("Timeout waiting for the expected writebacks, loads and stores");
			errs[KindCount]++;
		end
		cycles = 0;
		while (pc != '1 && cycles < Timeout)
		begin
			@(negedge clk);
			cycles++;
		end
		if (pc != '1)
		begin
			$display("Timeout waiting for the pc to reach the end of the program space");
			errs[KindCount]++;
		end
		checks[KindCount]++;
		assert (expWb.size() == 0 && expSt.size() == 0 && expLd.size() == 0)
		else
		begin
			$display("%0d writebacks, %0d loads and %0d stores never appeared",
				expWb.size(), expLd.size(), expSt.size());
			errs[KindCount]++;
		end

		totalChecks = 0;
		totalErrs = 0;
		for (int t = 1; t < 6; t++)
			$display("Test %s: %0d checks, %0d errors", testNames[t], checks[t], errs[t]);
		for (int t = 0; t < 6; t++)
		begin
			totalChecks += checks[t];
			totalErrs += errs[t];
		end
		$display("Total: %0d checks, %0d errors", totalChecks, totalErrs);
		if (totalErrs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== test/rvCore_sva.sv ====
// --------------------------------------------------
// Stall, writeback and data port assertions for rvCore
// --------------------------------------------------

`timescale 1ns/1ns

module rvCoreSva (
	input logic clk,
	input logic async_reset,
	input logic stall,
	input rvPkg::wbT wb,
	input logic dataWrite,
	input logic dataRead
);

	// A load-use hazard costs one bubble
	assert property (@(posedge clk) disable iff (!async_reset) stall |=> !stall)
	else $error("stall held high for two consecutive cycles");

	assert property (@(posedge clk) disable iff (!async_reset) wb.valid |-> wb.rd != '0)
	else $error("writeback valid with rd x0");

	assert property (@(posedge clk) disable iff (!async_reset) !(dataWrite && dataRead))
	else $error("dataWrite and dataRead high together");

endmodule

bind rvCore rvCoreSva sva (
	.clk(clk),
	.async_reset(async_reset),
	.stall(stall),
	.wb(wb),
	.dataWrite(dataWrite),
	.dataRead(dataRead)
);
